//--- verilog/quant_pkg.sv
`default_nettype none

package quant_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // array geometry
    ////////////////////////////////////////////////////////////////////////////

    // columns of the conv core feeding this stage
    localparam int column_num        = 4;
    // pixels each pe column delivers per channel
    localparam int pe_parallel_pixel = 2;
    localparam int lanes_per_channel = column_num * pe_parallel_pixel;
    // two channels worth of lanes in mode_18
    localparam int lane_count        = 16;

    // input pixel widths per mode with bias headroom included
    localparam int pixel_width_88 = 24;
    localparam int pixel_width_18 = 16;
    localparam int acc_row_width  = 384;

    // multiplier operands and product
    localparam int mult_a_width = 24;
    localparam int mult_b_width = 16;
    localparam int mult_p_width = 40;

    // per-channel scale is mantissa (tail) and right shift (rank)
    localparam int scale_tail_width  = 16;
    localparam int scale_rank_width  = 8;
    localparam int quant_pixel_width = 8;

    localparam int scale_table_depth = 16;
    localparam int scale_addr_width  = 4;

    // row strobe to out strobe
    localparam int pipe_latency = 4;

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    // one 24 bit channel, or two 16 bit channels
    typedef enum logic {
        mode_88 = 1'b0,
        mode_18 = 1'b1
    } quant_mode_e;

    // channel 0 uses tail_0 and rank_0
    // the second pair idles in mode_88
    typedef struct packed {
        logic [scale_tail_width-1:0] tail_0;
        logic [scale_tail_width-1:0] tail_1;
        logic [scale_rank_width-1:0] rank_0;
        logic [scale_rank_width-1:0] rank_1;
    } scale_set_t;

    typedef struct packed {
        logic [lane_count-1:0][mult_a_width-1:0] a_row;
        logic [lane_count-1:0][mult_b_width-1:0] b_row;
    } mult_operands_t;

    typedef logic [lane_count-1:0][mult_p_width-1:0] product_row_t;
    typedef logic [lane_count-1:0][quant_pixel_width-1:0] quant_row_t;

endpackage

`default_nettype wire

//--- verilog/scale_set_table.sv
`default_nettype none

module scale_set_table (
    input  wire logic                                  clk,
    input  wire logic                                  load_en,
    input  wire logic [quant_pkg::scale_addr_width-1:0] load_addr,
    input  quant_pkg::scale_set_t                      load_set,
    input  wire logic [quant_pkg::scale_addr_width-1:0] rd_addr,
    output quant_pkg::scale_set_t                      rd_set
);

    import quant_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // scale set storage
    ////////////////////////////////////////////////////////////////////////////

    // one entry per channel pair
    scale_set_t mem [scale_table_depth];

    // write port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_set;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////////////

    // data lands one cycle after the row strobe
    // read runs every cycle
    // idle reads are ignored downstream
    // a write one cycle earlier is already in mem here
    always_ff @(posedge clk) begin
        rd_set <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- verilog/quant_pipe_ctrl.sv
`default_nettype none

module quant_pipe_ctrl (
    input  wire logic                               clk,
    input  wire logic                               e_tail_reset,
    input  wire logic                               row_strobe,
    input  wire logic [quant_pkg::acc_row_width-1:0] acc_row,
    input  quant_pkg::quant_row_t                   scaled_row,
    output logic      [quant_pkg::acc_row_width-1:0] aligned_row,
    output logic                                    out_strobe,
    output quant_pkg::quant_row_t                   out_row
);

    import quant_pkg::*;

    // strobe_pipe[k] is the row strobe delayed by k+1 cycles
    logic [pipe_latency-1:0]  strobe_pipe;
    logic [acc_row_width-1:0] row_d1;

    ////////////////////////////////////////////////////////////////////////////
    // strobe delay line
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            strobe_pipe <= '0;
        end else begin
            strobe_pipe <= {strobe_pipe[pipe_latency-2:0], row_strobe};
        end
    end

    // last stage marks the quantized row as valid
    assign out_strobe = strobe_pipe[pipe_latency-1];

    ////////////////////////////////////////////////////////////////////////////
    // row alignment
    ////////////////////////////////////////////////////////////////////////////

    // two stages so the pixels meet the registered tails
    // first one covers the table read
    always_ff @(posedge clk) begin
        row_d1      <= acc_row;
        aligned_row <= row_d1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // quantized output register
    ////////////////////////////////////////////////////////////////////////////

    // products sit in the multiplier register on the third stage
    // holds between strobes
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            out_row <= '0;
        end else if (strobe_pipe[2]) begin
            out_row <= scaled_row;
        end
    end

endmodule

`default_nettype wire

//--- verilog/e_scale.sv
`default_nettype none

module e_scale (
    input  wire logic                               clk,
    input  wire logic                               e_tail_reset,
    input  quant_pkg::quant_mode_e                  mode,
    input  quant_pkg::scale_set_t                   scale_set,
    input  wire logic [quant_pkg::acc_row_width-1:0] acc_row,
    output quant_pkg::mult_operands_t               operands,
    input  quant_pkg::product_row_t                 products,
    output quant_pkg::quant_row_t                   scaled_row
);

    import quant_pkg::*;

    logic [scale_tail_width-1:0] tail_0_q;
    logic [scale_tail_width-1:0] tail_1_q;
    logic [scale_rank_width-1:0] rank_0_d;
    logic [scale_rank_width-1:0] rank_1_d;
    logic [scale_rank_width-1:0] rank_0_q;
    logic [scale_rank_width-1:0] rank_1_q;

    ////////////////////////////////////////////////////////////////////////////
    // tail and rank staging
    ////////////////////////////////////////////////////////////////////////////

    // tails meet the aligned row, ranks meet the products one cycle later
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            tail_0_q <= '0;
            tail_1_q <= '0;
            rank_0_d <= '0;
            rank_1_d <= '0;
            rank_0_q <= '0;
            rank_1_q <= '0;
        end else begin
            tail_0_q <= scale_set.tail_0;
            tail_1_q <= scale_set.tail_1;
            rank_0_d <= scale_set.rank_0;
            rank_1_d <= scale_set.rank_1;
            rank_0_q <= rank_0_d;
            rank_1_q <= rank_1_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lane i is channel 0 and lane i+8 is channel 1
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < lanes_per_channel; i++) begin : g_pair
        logic [mult_p_width-1:0]      prod_lo;
        logic [mult_p_width-1:0]      prod_hi;
        logic [mult_p_width-1:0]      shift_lo;
        logic [mult_p_width-1:0]      shift_hi;
        logic [quant_pixel_width:0]   keep_lo;
        logic [quant_pixel_width:0]   keep_hi;

        // pixel operands are zero extended
        // mode_18 second channel starts at bit 128
        assign operands.a_row[i] = (mode == mode_88) ?
            mult_a_width'(acc_row[i*pixel_width_88 +: pixel_width_88]) :
            mult_a_width'(acc_row[i*pixel_width_18 +: pixel_width_18]);
        assign operands.a_row[lanes_per_channel+i] = (mode == mode_18) ?
            mult_a_width'(acc_row[(lanes_per_channel+i)*pixel_width_18 +: pixel_width_18]) :
            '0;

        // tail broadcast per channel
        assign operands.b_row[i] = mult_b_width'(tail_0_q);
        assign operands.b_row[lanes_per_channel+i] = (mode == mode_18) ?
            mult_b_width'(tail_1_q) : '0;

        // full 40 bit product in mode_88, low 32 bits in mode_18
        assign prod_lo = (mode == mode_88) ? products[i] :
            mult_p_width'(products[i][pixel_width_18+scale_tail_width-1:0]);
        assign prod_hi = (mode == mode_18) ?
            mult_p_width'(products[lanes_per_channel+i][pixel_width_18+scale_tail_width-1:0]) :
            '0;

        assign shift_lo = prod_lo >> rank_0_q;
        assign shift_hi = prod_hi >> rank_1_q;

        // nine bits are kept and bit 8 flags overflow
        assign keep_lo = shift_lo[quant_pixel_width:0];
        assign keep_hi = shift_hi[quant_pixel_width:0];

        // overflow gives zero, not 255
        assign scaled_row[i] = keep_lo[quant_pixel_width] ?
            '0 : keep_lo[quant_pixel_width-1:0];
        assign scaled_row[lanes_per_channel+i] = keep_hi[quant_pixel_width] ?
            '0 : keep_hi[quant_pixel_width-1:0];
    end

endmodule

`default_nettype wire

//--- verilog/scale_mult_array.sv
`default_nettype none

module scale_mult_array (
    input  wire logic                 clk,
    input  wire logic                 e_tail_reset,
    input  quant_pkg::mult_operands_t operands,
    output quant_pkg::product_row_t   products
);

    import quant_pkg::*;

    // unregistered lane products
    product_row_t prod_d;

    ////////////////////////////////////////////////////////////////////////////
    // lane multipliers
    ////////////////////////////////////////////////////////////////////////////

    // unsigned 24 x 16 product fits 40 bits exactly
    for (genvar l = 0; l < lane_count; l++) begin : g_lane
        assign prod_d[l] = mult_p_width'(operands.a_row[l]) *
                           mult_p_width'(operands.b_row[l]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    // single stage standing in for the dsp pipeline
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            products <= '0;
        end else begin
            products <= prod_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/quant_unit_top.sv
`default_nettype none

module quant_unit_top (
    input  wire logic                                  clk,
    input  wire logic                                  e_tail_reset,
    input  quant_pkg::quant_mode_e                     mode,
    input  wire logic                                  load_en,
    input  wire logic [quant_pkg::scale_addr_width-1:0] load_addr,
    input  quant_pkg::scale_set_t                      load_set,
    input  wire logic                                  row_strobe,
    input  wire logic [quant_pkg::scale_addr_width-1:0] row_addr,
    input  wire logic [quant_pkg::acc_row_width-1:0]    acc_row,
    output logic                                       out_strobe,
    output quant_pkg::quant_row_t                      out_row
);

    import quant_pkg::*;

    scale_set_t               rd_set;
    logic [acc_row_width-1:0] aligned_row;
    mult_operands_t           operands;
    product_row_t             products;
    quant_row_t               scaled_row;

    // set for the row arrives at T+1
    scale_set_table i_table (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_set  (load_set),
        .rd_addr   (row_addr),
        .rd_set    (rd_set)
    );

    // strobe timing, row alignment and output register
    quant_pipe_ctrl i_ctrl (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .row_strobe   (row_strobe),
        .acc_row      (acc_row),
        .scaled_row   (scaled_row),
        .aligned_row  (aligned_row),
        .out_strobe   (out_strobe),
        .out_row      (out_row)
    );

    // formats operands at T+2, quantizes products at T+3
    e_scale i_scale (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .mode         (mode),
        .scale_set    (rd_set),
        .acc_row      (aligned_row),
        .operands     (operands),
        .products     (products),
        .scaled_row   (scaled_row)
    );

    scale_mult_array i_mult (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .operands     (operands),
        .products     (products)
    );

endmodule

`default_nettype wire

//--- testbench/quant_unit_props.sv
`default_nettype none

module quant_unit_props (
    input  wire logic            clk,
    input  wire logic            e_tail_reset,
    input  wire logic            row_strobe,
    input  wire logic            out_strobe,
    input  quant_pkg::quant_row_t out_row
);

    import quant_pkg::*;

    // number of failing assertions seen so far
    int fail_count = 0;

    // every accepted row leaves exactly pipe_latency cycles later
    a_latency: assert property (@(posedge clk) disable iff (e_tail_reset)
        row_strobe |-> ##pipe_latency out_strobe)
        else begin
            fail_count++;
            $error("out_strobe missing %0d cycles after row_strobe", pipe_latency);
        end

    // quiet while in reset and on the first cycle out of it
    a_reset_quiet: assert property (@(posedge clk) $past(e_tail_reset) |-> !out_strobe)
        else begin
            fail_count++;
            $error("out_strobe high during or right after reset");
        end

    // output register only moves together with a strobe
    a_hold: assert property (@(posedge clk) disable iff (e_tail_reset)
        !out_strobe |-> $stable(out_row))
        else begin
            fail_count++;
            $error("out_row changed without out_strobe");
        end

endmodule

bind quant_pipe_ctrl quant_unit_props i_props (
    .clk          (clk),
    .e_tail_reset (e_tail_reset),
    .row_strobe   (row_strobe),
    .out_strobe   (out_strobe),
    .out_row      (out_row)
);

`default_nettype wire

//--- testbench/quant_unit_tb.sv
`default_nettype none

module quant_unit_tb;

    import quant_pkg::*;

    logic                        clk;
    logic                        e_tail_reset;
    quant_mode_e                 mode;
    logic                        load_en;
    logic [scale_addr_width-1:0] load_addr;
    scale_set_t                  load_set;
    logic                        row_strobe;
    logic [scale_addr_width-1:0] row_addr;
    logic [acc_row_width-1:0]    acc_row;
    logic                        out_strobe;
    quant_row_t                  out_row;

    integer     seed = 34651;
    int         checks = 0;
    int         errors = 0;
    int         timeouts = 0;
    // model of the scale table that mirrors each write
    scale_set_t table_model [scale_table_depth];
    // expected rows in issue order
    quant_row_t exp_q [$];
    // expected value of the latest issued row
    quant_row_t held;

    quant_unit_top i_dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // lanes 0 to 7 are channel 0, lanes 8 to 15 channel 1 (mode_18 only)
    // nine bits survive the shift and bit 8 forces zero
    function automatic quant_row_t quant_expected(input quant_mode_e m,
                                                  input logic [acc_row_width-1:0] row,
                                                  input scale_set_t s);
        quant_row_t  res;
        logic [63:0] px;
        logic [63:0] prod;
        logic [15:0] tail;
        logic [7:0]  rank;
        for (int l = 0; l < lane_count; l++) begin
            if (m == mode_88) begin
                px = (l < lanes_per_channel) ?
                    64'(row[l*pixel_width_88 +: pixel_width_88]) : '0;
            end else begin
                px = 64'(row[l*pixel_width_18 +: pixel_width_18]);
            end
            tail = (l < lanes_per_channel) ? s.tail_0 : s.tail_1;
            rank = (l < lanes_per_channel) ? s.rank_0 : s.rank_1;
            prod = (px * 64'(tail)) >> rank;
            res[l] = prod[8] ? 8'd0 : prod[7:0];
        end
        return res;
    endfunction

    function automatic logic [acc_row_width-1:0] rand_row();
        logic [acc_row_width-1:0] r;
        for (int w = 0; w < acc_row_width / 32; w++) begin
            r[w*32 +: 32] = $random(seed);
        end
        return r;
    endfunction

    // ranks from 16 up keep a fair share of lanes out of overflow
    function automatic scale_set_t rand_set();
        scale_set_t s;
        s.tail_0 = 16'($random(seed));
        s.tail_1 = 16'($random(seed));
        s.rank_0 = 8'(16 + ({$random(seed)} % 32));
        s.rank_1 = 8'(16 + ({$random(seed)} % 16));
        return s;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // inputs change 2 units after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_set(input logic [scale_addr_width-1:0] addr, input scale_set_t s);
        load_en   = 1'b1;
        load_addr = addr;
        load_set  = s;
        table_model[addr] = s;
        next_cycle();
        load_en = 1'b0;
    endtask

    // expected value is fixed at issue since mode stays put while rows fly
    task automatic issue_row(input logic [scale_addr_width-1:0] addr,
                             input logic [acc_row_width-1:0] row);
        row_strobe = 1'b1;
        row_addr   = addr;
        acc_row    = row;
        held       = quant_expected(mode, row, table_model[addr]);
        exp_q.push_back(held);
        next_cycle();
        row_strobe = 1'b0;
    endtask

    task automatic check_out(input quant_row_t exp);
        checks++;
        if (out_row !== exp) begin
            errors++;
            $display("error at %0t: out_row %h, expected %h", $time, out_row, exp);
        end
    endtask

    // wait until every issued row has come out
    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("timeout: %0d rows never produced out_strobe", exp_q.size());
            exp_q.delete();
        end
        next_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // comparison at the falling edge where outputs are settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!e_tail_reset && out_strobe) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_strobe at %0t with no row pending", $time);
            end else begin
                check_out(exp_q.pop_front());
            end
        end
    end

    initial begin
        e_tail_reset = 1'b1;
        mode         = mode_88;
        load_en      = 1'b0;
        load_addr    = '0;
        load_set     = '0;
        row_strobe   = 1'b0;
        row_addr     = '0;
        acc_row      = '0;
        repeat (10) @(posedge clk);
        #2;
        e_tail_reset = 1'b0;
        // output register comes out of reset cleared
        @(negedge clk);
        check_out('0);
        next_cycle();

        // mode_88 with a small tail leaves the upper lanes zero
        write_set(4'd0, '{tail_0: 16'd3, tail_1: 16'd0, rank_0: 8'd16, rank_1: 8'd0});
        repeat (6) issue_row(4'd0, rand_row());
        drain();

        // mode_18 with each channel on its own tail and rank
        mode = mode_18;
        write_set(4'd1, '{tail_0: 16'd5, tail_1: 16'd200, rank_0: 8'd10, rank_1: 8'd14});
        repeat (6) issue_row(4'd1, rand_row());
        drain();

        // 256 unshifted sets bit 8 so the lane drops to zero
        mode = mode_88;
        write_set(4'd2, '{tail_0: 16'd1, tail_1: 16'd0, rank_0: 8'd0, rank_1: 8'd0});
        issue_row(4'd2, 384'd256);
        drain();
        check_out(quant_row_t'(0));
        // one more bit of shift gives 128
        write_set(4'd2, '{tail_0: 16'd1, tail_1: 16'd0, rank_0: 8'd1, rank_1: 8'd0});
        issue_row(4'd2, 384'd256);
        drain();
        check_out(quant_row_t'(128));

        // back to back rows over random table entries in both modes
        for (int a = 3; a < scale_table_depth; a++) begin
            write_set(4'(a), rand_set());
        end
        for (int m = 0; m < 2; m++) begin
            mode = (m == 0) ? mode_18 : mode_88;
            repeat (32) issue_row(4'(3 + {$random(seed)} % 13), rand_row());
            drain();
        end

        // row on the cycle right after a rewrite sees the new set
        write_set(4'd5, rand_set());
        issue_row(4'd5, rand_row());
        drain();

        // new pixels without a strobe must leave out_row alone
        repeat (8) begin
            acc_row = rand_row();
            next_cycle();
        end
        check_out(held);

        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, i_dut.i_ctrl.i_props.fail_count);
        if (errors + timeouts + i_dut.i_ctrl.i_props.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/quant_pkg.sv
verilog/scale_set_table.sv
verilog/quant_pipe_ctrl.sv
verilog/e_scale.sv
verilog/scale_mult_array.sv
verilog/quant_unit_top.sv
testbench/quant_unit_props.sv
testbench/quant_unit_tb.sv
